//--- hw/ua_pkg.sv
package ua_pkg;

    // byte and word geometry
    localparam int BYTE_W     = 8;
    localparam int WORD_BYTES = 4;
    localparam int WORD_W     = BYTE_W * WORD_BYTES;
    localparam int ADDR_W     = 32;

    // low address bits select the byte lane, the rest select the word
    localparam int OFFSET_W = $clog2(WORD_BYTES);
    localparam int INDEX_W  = ADDR_W - OFFSET_W;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_BYTES-1:0] strb_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [INDEX_W-1:0]  index_t;

    // two adjacent words, hi above lo, little-endian byte order
    typedef logic [2*WORD_W-1:0] window_t;

    // request as seen on the external port
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } req_t;

    // one word access to the internal memory
    typedef struct packed {
        logic   write;
        index_t index;
        word_t  wdata;
    } mem_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_LO,
        READ_HI,
        WAIT_HI,
        WRITE_LO,
        WRITE_HI,
        RESPOND
    } seq_state_t;

    // byte lane of the addressed byte
    function automatic offset_t addr_offset(addr_t addr);
        return addr[OFFSET_W-1:0];
    endfunction

    // word index holding the addressed byte
    function automatic index_t addr_index(addr_t addr);
        return addr[ADDR_W-1:OFFSET_W];
    endfunction

endpackage

//--- hw/word_memory.sv
`timescale 1ns/1ps

module word_memory #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mem_cmd_valid,
    input  ua_pkg::mem_cmd_t mem_cmd,
    output ua_pkg::word_t    mem_rdata,
    output logic             mem_rdata_valid
);
    import ua_pkg::*;

    localparam int SLOT_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

    word_t             mem [DEPTH_WORDS];
    logic [SLOT_W-1:0] slot;

    // word index wraps around the array depth
    assign slot = SLOT_W'(mem_cmd.index % DEPTH_WORDS);

    always_ff @(posedge clk) begin
        if (mem_cmd_valid) begin
            if (mem_cmd.write) begin
                mem[slot] <= mem_cmd.wdata;
            end else begin
                mem_rdata <= mem[slot];
            end
        end
    end

    // read data shows up one cycle after the command
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_rdata_valid <= 1'b0;
        end else begin
            mem_rdata_valid <= mem_cmd_valid && !mem_cmd.write;
        end
    end

endmodule

//--- hw/read_realign.sv
`timescale 1ns/1ps

module read_realign (
    input  ua_pkg::req_t  req_q,
    input  ua_pkg::word_t lo_q,
    input  ua_pkg::word_t hi_q,
    output ua_pkg::word_t rdata_aligned
);
    import ua_pkg::*;

    window_t window;
    offset_t offset;

    assign offset = addr_offset(req_q.addr);

    // hi word sits above lo word, so byte n of the window is
    // byte n of lo for n < 4 and byte n-4 of hi otherwise
    assign window = {hi_q, lo_q};

    always_comb begin
        rdata_aligned = '0;
        // result byte i comes from window byte offset+i
        for (int i = 0; i < WORD_BYTES; i++) begin
            rdata_aligned[i*BYTE_W +: BYTE_W] =
                window[(int'(offset) + i)*BYTE_W +: BYTE_W];
        end
    end

    // at offset 0 this picks lo_q as is, and hi_q is never looked at
    // offset 3 takes the top byte of lo and the low three bytes of hi

endmodule

//--- hw/write_merge.sv
`timescale 1ns/1ps

module write_merge (
    input  ua_pkg::req_t  req_q,
    input  ua_pkg::word_t lo_q,
    input  ua_pkg::word_t hi_q,
    output ua_pkg::word_t new_lo,
    output ua_pkg::word_t new_hi
);
    import ua_pkg::*;

    // one strobe bit per byte of the two word window
    typedef logic [2*WORD_BYTES-1:0] wstrb_t;

    offset_t offset;
    window_t old_window;
    window_t new_data;
    wstrb_t  new_strb;
    window_t merged;

    assign offset     = addr_offset(req_q.addr);
    assign old_window = {hi_q, lo_q};

    // move write bytes and strobes up to the addressed lane
    assign new_data = window_t'(req_q.wdata) << (int'(offset) * BYTE_W);
    assign new_strb = wstrb_t'(req_q.strb) << offset;

    always_comb begin
        merged = old_window;
        // strobed bytes replace the old ones, others keep memory contents
        for (int b = 0; b < 2*WORD_BYTES; b++) begin
            if (new_strb[b]) begin
                merged[b*BYTE_W +: BYTE_W] = new_data[b*BYTE_W +: BYTE_W];
            end
        end
    end

    // lower half goes back to the low word, upper half to the next word
    assign new_lo = merged[WORD_W-1:0];
    assign new_hi = merged[2*WORD_W-1:WORD_W];

    // with a zero offset the whole strobe lands in the low word
    // and new_hi is just hi_q unchanged, so it is never written back

endmodule

//--- hw/access_sequencer.sv
`timescale 1ns/1ps

module access_sequencer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    output logic             req_ready,
    input  ua_pkg::req_t     req,
    output logic             rsp_valid,
    input  logic             rsp_ready,
    output ua_pkg::word_t    rsp_rdata,
    output logic             mem_cmd_valid,
    output ua_pkg::mem_cmd_t mem_cmd,
    input  ua_pkg::word_t    mem_rdata,
    input  logic             mem_rdata_valid,
    output ua_pkg::req_t     req_q,
    output ua_pkg::word_t    lo_q,
    output ua_pkg::word_t    hi_q,
    input  ua_pkg::word_t    rdata_aligned,
    input  ua_pkg::word_t    new_lo,
    input  ua_pkg::word_t    new_hi
);
    import ua_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;
    logic       accept;
    logic       unaligned_q;
    logic       load_rsp;
    index_t     index_lo;
    index_t     index_hi;

    // aligned write with every byte enabled needs no old data
    function automatic logic full_aligned_write(req_t r);
        return r.write && (addr_offset(r.addr) == '0) && (&r.strb);
    endfunction

    // only IDLE takes new requests
    assign req_ready = (state == IDLE);
    assign accept    = req_valid && req_ready;

    assign unaligned_q = (addr_offset(req_q.addr) != '0);

    // second word of an unaligned access, memory wraps it by depth
    assign index_lo = addr_index(req_q.addr);
    assign index_hi = index_lo + index_t'(1);

    // first cycle in RESPOND captures the realigned word
    assign load_rsp = (state == RESPOND) && !rsp_valid;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = full_aligned_write(req) ? WRITE_LO : READ_LO;
                end
            end
            READ_LO: begin
                // low word arrives here
                if (mem_rdata_valid) begin
                    if (unaligned_q) begin
                        state_nxt = READ_HI;
                    end else if (req_q.write) begin
                        state_nxt = WRITE_LO;
                    end else begin
                        state_nxt = RESPOND;
                    end
                end
            end
            READ_HI: begin
                state_nxt = WAIT_HI;
            end
            WAIT_HI: begin
                if (mem_rdata_valid) begin
                    state_nxt = req_q.write ? WRITE_LO : RESPOND;
                end
            end
            WRITE_LO: begin
                state_nxt = unaligned_q ? WRITE_HI : IDLE;
            end
            WRITE_HI: begin
                state_nxt = IDLE;
            end
            RESPOND: begin
                if (rsp_valid && rsp_ready) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // memory commands
    always_comb begin
        mem_cmd_valid = 1'b0;
        mem_cmd       = '0;
        case (state)
            IDLE: begin
                // low word read goes out together with the accept
                mem_cmd_valid = accept && !full_aligned_write(req);
                mem_cmd.index = addr_index(req.addr);
            end
            READ_HI: begin
                mem_cmd_valid = 1'b1;
                mem_cmd.index = index_hi;
            end
            WRITE_LO: begin
                mem_cmd_valid = 1'b1;
                mem_cmd.write = 1'b1;
                mem_cmd.index = index_lo;
                // full strobe overwrites every lo_q byte even when nothing was fetched
                mem_cmd.wdata = new_lo;
            end
            WRITE_HI: begin
                mem_cmd_valid = 1'b1;
                mem_cmd.write = 1'b1;
                mem_cmd.index = index_hi;
                mem_cmd.wdata = new_hi;
            end
            default: begin
                mem_cmd_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            rsp_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            // valid held until the consumer takes the word
            if (load_rsp) begin
                rsp_valid <= 1'b1;
            end else if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // captured request, fetched words and response data
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if ((state == READ_LO) && mem_rdata_valid) begin
            lo_q <= mem_rdata;
        end
        if ((state == WAIT_HI) && mem_rdata_valid) begin
            hi_q <= mem_rdata;
        end
        if (load_rsp) begin
            rsp_rdata <= rdata_aligned;
        end
    end

endmodule

//--- hw/unaligned_access_ctrl.sv
`timescale 1ns/1ps

module unaligned_access_ctrl #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          req_valid,
    output logic          req_ready,
    input  ua_pkg::req_t  req,
    output logic          rsp_valid,
    input  logic          rsp_ready,
    output ua_pkg::word_t rsp_rdata
);
    import ua_pkg::*;

    // sequencer to memory
    logic     mem_cmd_valid;
    mem_cmd_t mem_cmd;
    word_t    mem_rdata;
    logic     mem_rdata_valid;

    // sequencer to datapath and back
    req_t  req_q;
    word_t lo_q;
    word_t hi_q;
    word_t rdata_aligned;
    word_t new_lo;
    word_t new_hi;

    access_sequencer i_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req             (req),
        .rsp_valid       (rsp_valid),
        .rsp_ready       (rsp_ready),
        .rsp_rdata       (rsp_rdata),
        .mem_cmd_valid   (mem_cmd_valid),
        .mem_cmd         (mem_cmd),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid),
        .req_q           (req_q),
        .lo_q            (lo_q),
        .hi_q            (hi_q),
        .rdata_aligned   (rdata_aligned),
        .new_lo          (new_lo),
        .new_hi          (new_hi)
    );

    // read and write paths both look at the same captured words
    read_realign i_read_realign (
        .req_q         (req_q),
        .lo_q          (lo_q),
        .hi_q          (hi_q),
        .rdata_aligned (rdata_aligned)
    );

    write_merge i_write_merge (
        .req_q  (req_q),
        .lo_q   (lo_q),
        .hi_q   (hi_q),
        .new_lo (new_lo),
        .new_hi (new_hi)
    );

    word_memory #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_word_memory (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_cmd_valid   (mem_cmd_valid),
        .mem_cmd         (mem_cmd),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

endmodule

//--- test/tb_unaligned_access_ctrl.sv
`timescale 1ns/1ps

module tb_unaligned_access_ctrl;
    import ua_pkg::*;

    localparam int DEPTH_WORDS    = 256;
    localparam int MEM_BYTES      = DEPTH_WORDS * WORD_BYTES;
    localparam int N_RANDOM       = 200;
    localparam int CYCLES_PER_REQ = 40;

    logic  clk;
    logic  rst_n;
    logic  req_valid;
    logic  req_ready;
    req_t  req;
    logic  rsp_valid;
    logic  rsp_ready;
    word_t rsp_rdata;

    // byte-wide reference memory, byte a sits in word a/4 lane a%4
    logic [7:0] model_mem [MEM_BYTES];
    integer     seed;

    // stimulus table, one entry per request
    string t_name[$];
    logic  t_write[$];
    addr_t t_addr[$];
    word_t t_wdata[$];
    strb_t t_strb[$];
    word_t t_exp[$];
    int    t_stall[$];

    unaligned_access_ctrl #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // every request gets a fixed budget of cycles
    initial begin
        wait (rst_n === 1'b1);
        repeat ((DEPTH_WORDS + t_name.size() + N_RANDOM) * CYCLES_PER_REQ) @(posedge clk);
        $display("watchdog expired before all requests completed");
        $display("ERRORS FOUND");
        $fatal(1, "simulation timed out");
    end

    // initial word contents, every byte depends on the full word index
    function automatic word_t fill_word(int w);
        return {8'(w), 8'(~w), 8'(w ^ 'ha5), 8'(w + 'h3c)};
    endfunction

    // four bytes from the reference, wrapping at the end of memory
    function automatic word_t model_read(addr_t addr);
        int    base;
        word_t result;
        base = int'(addr % MEM_BYTES);
        for (int i = 0; i < WORD_BYTES; i++) begin
            result[i*8 +: 8] = model_mem[(base + i) % MEM_BYTES];
        end
        return result;
    endfunction

    task automatic model_write(addr_t addr, word_t wdata, strb_t strb);
        int base;
        base = int'(addr % MEM_BYTES);
        for (int i = 0; i < WORD_BYTES; i++) begin
            if (strb[i]) begin
                model_mem[(base + i) % MEM_BYTES] = wdata[i*8 +: 8];
            end
        end
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        assert (act === exp) else begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond === 1'b1) else begin
            $display("protocol check failed: %s", what);
            $display("ERRORS FOUND");
            $fatal(1, "protocol violation");
        end
    endtask

    task automatic add_entry(string name, logic write, addr_t addr, word_t wdata,
                             strb_t strb, word_t exp, int stall);
        t_name.push_back(name);
        t_write.push_back(write);
        t_addr.push_back(addr);
        t_wdata.push_back(wdata);
        t_strb.push_back(strb);
        t_exp.push_back(exp);
        t_stall.push_back(stall);
    endtask

    task automatic build_table();
        // full aligned writes, then aligned and unaligned reads of them
        add_entry("wr_full_w0", 1'b1, 32'd0, 32'hcafebebe, 4'hf, 32'h0, 0);
        add_entry("wr_full_w1", 1'b1, 32'd4, 32'hdeadbeef, 4'hf, 32'h0, 0);
        add_entry("rd_w0", 1'b0, 32'd0, 32'h0, 4'h0, 32'hcafebebe, 0);
        add_entry("rd_w1", 1'b0, 32'd4, 32'h0, 4'h0, 32'hdeadbeef, 0);
        add_entry("rd_off1", 1'b0, 32'd1, 32'h0, 4'h0, 32'hefcafebe, 0);
        add_entry("rd_off2", 1'b0, 32'd2, 32'h0, 4'h0, 32'hbeefcafe, 0);
        add_entry("rd_off3", 1'b0, 32'd3, 32'h0, 4'h0, 32'hadbeefca, 0);
        // partial aligned write touches bytes 0 and 2
        add_entry("wr_strb_0101", 1'b1, 32'd0, 32'h11223344, 4'h5, 32'h0, 0);
        add_entry("rd_merge", 1'b0, 32'd0, 32'h0, 4'h0, 32'hca22be44, 0);
        // unaligned write spans bytes 3 to 6
        add_entry("wr_unal_3", 1'b1, 32'd3, 32'h55667788, 4'hf, 32'h0, 0);
        add_entry("rd_lo_half", 1'b0, 32'd0, 32'h0, 4'h0, 32'h8822be44, 0);
        add_entry("rd_hi_half", 1'b0, 32'd4, 32'h0, 4'h0, 32'hde556677, 0);
        // response held off for several cycles
        add_entry("rd_stall", 1'b0, 32'd2, 32'h0, 4'h0, 32'h66778822, 6);
        // last word byte 2, high half comes from word 0
        add_entry("rd_wrap", 1'b0, 32'd1022, 32'h0, 4'h0, 32'hbe44ff00, 0);
        add_entry("wr_wrap", 1'b1, 32'd1022, 32'h99aabbcc, 4'hc, 32'h0, 0);
        add_entry("rd_wrap_after", 1'b0, 32'd1022, 32'h0, 4'h0, 32'h99aaff00, 0);
        add_entry("rd_w0_wrapped", 1'b0, 32'd0, 32'h0, 4'h0, 32'h882299aa, 0);
    endtask

    // one request through the port, reads return the response word
    task automatic issue_request(logic write, addr_t addr, word_t wdata, strb_t strb,
                                 int stall, output word_t rdata);
        word_t first;
        rdata = '0;
        @(negedge clk);
        req_valid  = 1'b1;
        req.write  = write;
        req.addr   = addr;
        req.wdata  = wdata;
        req.strb   = strb;
        while (!req_ready) @(negedge clk);
        // accepted on the edge just before this one
        @(negedge clk);
        req_valid = 1'b0;
        if (write) begin
            while (!req_ready) @(negedge clk);
        end else begin
            while (!rsp_valid) @(negedge clk);
            first = rsp_rdata;
            repeat (stall) begin
                @(negedge clk);
                check_true(rsp_valid, "rsp_valid dropped while rsp_ready was low");
                check_true(rsp_rdata === first, "rsp_rdata changed before it was taken");
                check_true(!req_ready, "req_ready rose while a response was pending");
            end
            rsp_ready = 1'b1;
            @(negedge clk);
            rsp_ready = 1'b0;
            check_true(!rsp_valid, "rsp_valid still high after rsp_ready");
            check_true(req_ready, "req_ready low after the response was taken");
            rdata = first;
        end
    endtask

    initial begin
        word_t       got;
        logic [31:0] r_bits;
        logic        r_write;
        addr_t       r_addr;
        word_t       r_wdata;
        strb_t       r_strb;
        seed      = 43;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        build_table();
        // reset spans two rising edges, released on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_true(req_ready, "req_ready low after reset");
        check_true(!rsp_valid, "rsp_valid high after reset");

        // give every word a known value through the port
        for (int w = 0; w < DEPTH_WORDS; w++) begin
            issue_request(1'b1, addr_t'(w * WORD_BYTES), fill_word(w), 4'hf, 0, got);
            model_write(addr_t'(w * WORD_BYTES), fill_word(w), 4'hf);
        end

        for (int k = 0; k < t_name.size(); k++) begin
            issue_request(t_write[k], t_addr[k], t_wdata[k], t_strb[k], t_stall[k], got);
            if (t_write[k]) begin
                model_write(t_addr[k], t_wdata[k], t_strb[k]);
            end else begin
                check_word(t_name[k], t_exp[k], got);
                check_word({t_name[k], "_model"}, model_read(t_addr[k]), got);
            end
        end

        // mixed random traffic against the byte model
        for (int n = 0; n < N_RANDOM; n++) begin
            r_bits  = $random(seed);
            r_write = r_bits[0];
            r_strb  = r_bits[4:1];
            r_addr  = {$random(seed)} % MEM_BYTES;
            r_wdata = $random(seed);
            issue_request(r_write, r_addr, r_wdata, r_strb, int'(r_bits[7:5]), got);
            if (r_write) begin
                model_write(r_addr, r_wdata, r_strb);
            end else begin
                check_word($sformatf("random_%0d", n), model_read(r_addr), got);
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- unaligned_access_ctrl.f
hw/ua_pkg.sv
hw/word_memory.sv
hw/read_realign.sv
hw/write_merge.sv
hw/access_sequencer.sv
hw/unaligned_access_ctrl.sv
test/tb_unaligned_access_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module tb_unaligned_access_ctrl \
    -f unaligned_access_ctrl.f
./obj_dir/Vtb_unaligned_access_ctrl
